//--- src/bridge_config.svh
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// **********************************************************************
// Host memory map
// **********************************************************************

// Addr[21:19] value that selects the 512 KB socket window
`define BRIDGE_WINDOW        3'b010

// Address bits of GPU RAM, offsets at or above 2**N read back FF
`define BRIDGE_RAM_BITS      15

// Base of the 16-byte bank-ID block, low nibble indexes the table
`define BRIDGE_BANK_ID_BASE  22'h17FFF0

// 1 returns the bank-ID table, 0 returns FF for that block
`define BRIDGE_BANK_RESPONSE 1

// **********************************************************************
// Host I/O ports
// **********************************************************************

`define BRIDGE_IO_SPKR       8'd242   // Speaker one-shot
`define BRIDGE_IO_BLNK       8'd243   // DAC blank control

`endif

//--- src/z80_bridge_pkg.sv
package z80_bridge_pkg;

   // **********************************************************************
   // Host side pins, sampled as levels in GPU_CLK
   // **********************************************************************
   typedef struct packed {
      logic        m1_n;      // Opcode fetch, active low
      logic        mreq_n;    // Memory request, active low
      logic        iorq_n;    // I/O request, active low
      logic        wr_n;      // Write strobe, active low
      logic        rd_n;      // Read strobe, active low
      logic [21:0] addr;      // Extended host address
      logic [7:0]  wdata;     // Host data toward GPU
   } z80_bus_t;

   // Classified bus cycle
   typedef enum logic [2:0] {
      OP_IDLE,
      OP_MEM_WRITE,
      OP_MEM_READ,
      OP_IO_SPKR,
      OP_IO_BLNK
   } cycle_op_e;

   typedef struct packed {
      cycle_op_e   op;        // Cycle class
      logic [18:0] offset;    // Offset inside the window
      logic [7:0]  wdata;     // Host write byte
      logic        in_range;  // Offset inside GPU RAM
      logic        bank_hit;  // Address in bank-ID block
      logic [3:0]  bank_idx;  // Table entry select
   } bus_cycle_t;

   // Request toward GPU RAM
   typedef struct packed {
      logic        wr_ena;    // One-cycle write pulse
      logic        rd_req;    // One-cycle read request
      logic [18:0] addr;
      logic [7:0]  wdata;
   } gpu_req_t;

   // Return path and level converter controls
   typedef struct packed {
      logic [7:0]  rdata;     // Byte for the host
      logic        rdata_ena; // Data valid toward host
      logic        dir_245;   // High drives toward Z80
      logic        oe_245_n;  // Converter enable, active low
   } z80_drive_t;

   // Bank identification bytes
   parameter logic [7:0] BANK_ID [0:15] = '{
      8'd9,  8'd3,  8'd71, 8'd80, 8'd85, 8'd32,  8'd69,  8'd80,
      8'd52, 8'd67, 8'd69, 8'd54, 8'd0,  8'd255, 8'd255, 8'd255
   };

endpackage

//--- src/z80_bus_decode.sv
`timescale 1ns/100ps
`include "bridge_config.svh"

module z80_bus_decode (
   input  logic                      GPU_CLK,
   input  logic                      reset,
   input  z80_bridge_pkg::z80_bus_t  bus,
   output z80_bridge_pkg::bus_cycle_t cycle
);
   import z80_bridge_pkg::*;

   localparam logic [21:0] BANK_BASE = `BRIDGE_BANK_ID_BASE;

   logic        mem_cyc;    // MREQ without opcode fetch
   logic        win_hit;    // Socket window selected
   logic        in_range;   // Below GPU RAM top
   logic        bank_hit;   // Bank-ID block selected
   cycle_op_e   next_op;
   cycle_op_e   op_q;
   logic [18:0] offset_q;
   logic [7:0]  wdata_q;
   logic        in_range_q;
   logic        bank_hit_q;
   logic [3:0]  bank_idx_q;

   // **********************************************************************
   // Address compares and cycle class
   // **********************************************************************
   assign mem_cyc  = !bus.mreq_n && bus.m1_n;
   assign win_hit  = (bus.addr[21:19] == `BRIDGE_WINDOW);
   assign in_range = win_hit && (bus.addr[18:0] < (19'd1 << `BRIDGE_RAM_BITS));
   assign bank_hit = (bus.addr[21:4] == BANK_BASE[21:4]);

   always_comb begin
      next_op = OP_IDLE;                                   // No strobe active
      if (mem_cyc && !bus.wr_n && in_range) begin
         next_op = OP_MEM_WRITE;                           // Writes only inside RAM
      end else if (mem_cyc && !bus.rd_n && win_hit) begin
         next_op = OP_MEM_READ;                            // Reads anywhere in window
      end else if (!bus.iorq_n && bus.m1_n && !bus.wr_n) begin
         if (bus.addr[7:0] == `BRIDGE_IO_SPKR)
            next_op = OP_IO_SPKR;
         else if (bus.addr[7:0] == `BRIDGE_IO_BLNK)
            next_op = OP_IO_BLNK;
      end
   end

   always_ff @(posedge GPU_CLK) begin
      if (reset)
         op_q <= OP_IDLE;
      else
         op_q <= next_op;                                  // One cycle of latency
   end

   always_ff @(posedge GPU_CLK) begin
      offset_q   <= bus.addr[18:0];                        // Payload follows the bus
      wdata_q    <= bus.wdata;
      in_range_q <= in_range;
      bank_hit_q <= bank_hit;
      bank_idx_q <= bus.addr[3:0];
   end

   assign cycle = '{op: op_q, offset: offset_q, wdata: wdata_q, in_range: in_range_q,
                    bank_hit: bank_hit_q, bank_idx: bank_idx_q};

   // Host never drives both strobes
   a_rd_wr_excl : assert property (@(posedge GPU_CLK) disable iff (reset)
      !(!bus.rd_n && !bus.wr_n));

endmodule

//--- src/gpu_access_sequencer.sv
`timescale 1ns/100ps

module gpu_access_sequencer (
   input  logic                       GPU_CLK,
   input  logic                       reset,
   input  z80_bridge_pkg::bus_cycle_t cycle,
   output z80_bridge_pkg::gpu_req_t   gpu
);
   import z80_bridge_pkg::*;

   cycle_op_e   prev_op;      // Class seen at last edge
   logic        new_wr;
   logic        new_rd;
   logic        wr_ena_q;
   logic        rd_req_q;
   logic [18:0] addr_q;
   logic [7:0]  wdata_q;

   // Pulse only on the first edge of a memory class
   assign new_wr = (cycle.op == OP_MEM_WRITE) && (prev_op != OP_MEM_WRITE);
   assign new_rd = (cycle.op == OP_MEM_READ) && (prev_op != OP_MEM_READ);

   always_ff @(posedge GPU_CLK) begin
      if (reset) begin
         prev_op  <= OP_IDLE;
         wr_ena_q <= 1'b0;
         rd_req_q <= 1'b0;
      end else begin
         prev_op  <= cycle.op;
         wr_ena_q <= new_wr;                               // Single write strobe
         rd_req_q <= new_rd;                               // Single read request
      end
   end

   always_ff @(posedge GPU_CLK) begin
      if (new_wr || new_rd) begin
         addr_q  <= cycle.offset;                          // Held for the whole access
         wdata_q <= cycle.wdata;
      end
   end

   assign gpu = '{wr_ena: wr_ena_q, rd_req: rd_req_q, addr: addr_q, wdata: wdata_q};

   a_wr_rd_excl : assert property (@(posedge GPU_CLK) disable iff (reset)
      !(gpu.wr_ena && gpu.rd_req));
   a_wr_single : assert property (@(posedge GPU_CLK) disable iff (reset)
      gpu.wr_ena |=> !gpu.wr_ena);
   a_rd_single : assert property (@(posedge GPU_CLK) disable iff (reset)
      gpu.rd_req |=> !gpu.rd_req);

endmodule

//--- src/io_port_control.sv
`timescale 1ns/100ps

module io_port_control (
   input  logic                       GPU_CLK,
   input  logic                       reset,
   input  z80_bridge_pkg::bus_cycle_t cycle,
   output logic                       spkr_en,
   output logic                       video_en
);
   import z80_bridge_pkg::*;

   cycle_op_e prev_op;          // For start-of-cycle detect
   logic      new_spkr;
   logic      new_blnk;

   // **********************************************************************
   // Port write edge detect
   // **********************************************************************
   assign new_spkr = (cycle.op == OP_IO_SPKR) && (prev_op != OP_IO_SPKR);
   assign new_blnk = (cycle.op == OP_IO_BLNK) && (prev_op != OP_IO_BLNK);

   always_ff @(posedge GPU_CLK) begin
      if (reset) begin
         prev_op  <= OP_IDLE;
         spkr_en  <= 1'b0;
         video_en <= 1'b1;                                 // Video on out of reset
      end else begin
         prev_op <= cycle.op;
         spkr_en <= new_spkr && (cycle.wdata != 8'h00);    // One-shot, zero is ignored
         if (new_blnk)
            video_en <= (cycle.wdata != 8'h00);            // Zero blanks the DAC
      end
   end

endmodule

//--- src/read_data_return.sv
`timescale 1ns/100ps
`include "bridge_config.svh"

module read_data_return (
   input  logic                       GPU_CLK,
   input  logic                       reset,
   input  z80_bridge_pkg::bus_cycle_t cycle,
   input  logic [7:0]                 gpu_rdata,
   input  logic                       gpu_rd_rdy,
   output z80_bridge_pkg::z80_drive_t drive
);
   import z80_bridge_pkg::*;

   logic       is_read;         // Host reading the window
   logic       is_mem;          // Any memory class
   logic       bank_ena;        // Bank-ID answer allowed
   logic [7:0] ret_byte;        // Byte picked for the host

   assign is_read  = (cycle.op == OP_MEM_READ);
   assign is_mem   = is_read || (cycle.op == OP_MEM_WRITE);
   assign bank_ena = cycle.bank_hit && (`BRIDGE_BANK_RESPONSE != 0);

   // **********************************************************************
   // Return byte select
   // **********************************************************************
   always_comb begin
      if (cycle.in_range)
         ret_byte = gpu_rdata;                             // GPU RAM contents
      else if (bank_ena)
         ret_byte = BANK_ID[cycle.bank_idx];               // Bank identification
      else
         ret_byte = 8'hFF;                                 // Above RAM top
   end

   // **********************************************************************
   // Data latch and converter controls
   // **********************************************************************
   always_ff @(posedge GPU_CLK) begin
      if (reset) begin
         drive.rdata     <= 8'h00;
         drive.rdata_ena <= 1'b0;
         drive.dir_245   <= 1'b0;                          // Toward FPGA
         drive.oe_245_n  <= 1'b1;                          // Converter off
      end else begin
         if (gpu_rd_rdy)
            drive.rdata <= ret_byte;                       // Holds until next answer
         drive.rdata_ena <= is_read;
         drive.dir_245   <= is_read;                       // Toward Z80 on reads
         drive.oe_245_n  <= !is_mem;
      end
   end

   // GPU answers only inside a host read
   a_rdy_in_read : assert property (@(posedge GPU_CLK) disable iff (reset)
      gpu_rd_rdy |-> (cycle.op == OP_MEM_READ));

endmodule

//--- src/z80_gpu_bridge.sv
`timescale 1ns/100ps

module z80_gpu_bridge (
   input  logic                       GPU_CLK,
   input  logic                       reset,
   input  z80_bridge_pkg::z80_bus_t   z80_bus,
   input  logic [7:0]                 gpu_rdata,
   input  logic                       gpu_rd_rdy,
   output z80_bridge_pkg::gpu_req_t   gpu,
   output z80_bridge_pkg::z80_drive_t z80_drive,
   output logic                       spkr_en,
   output logic                       video_en
);
   import z80_bridge_pkg::*;

   bus_cycle_t cycle;           // Registered cycle class, shared by all blocks

   // **********************************************************************
   // Bus cycle classification
   // **********************************************************************
   z80_bus_decode u_decode (
      .GPU_CLK (GPU_CLK),
      .reset   (reset),
      .bus     (z80_bus),
      .cycle   (cycle)
   );

   // GPU write and read pulses
   gpu_access_sequencer u_sequencer (
      .GPU_CLK (GPU_CLK),
      .reset   (reset),
      .cycle   (cycle),
      .gpu     (gpu)
   );

   // Speaker and blank ports
   io_port_control u_io (
      .GPU_CLK  (GPU_CLK),
      .reset    (reset),
      .cycle    (cycle),
      .spkr_en  (spkr_en),
      .video_en (video_en)
   );

   // Host read data and level converters
   read_data_return u_return (
      .GPU_CLK    (GPU_CLK),
      .reset      (reset),
      .cycle      (cycle),
      .gpu_rdata  (gpu_rdata),
      .gpu_rd_rdy (gpu_rd_rdy),
      .drive      (z80_drive)
   );

endmodule

//--- test/tb_z80_gpu_bridge.sv
`timescale 1ns/100ps
`include "bridge_config.svh"

module tb_z80_gpu_bridge;
   import z80_bridge_pkg::*;

   localparam logic [21:0] BANK_BASE = `BRIDGE_BANK_ID_BASE;
   localparam logic [7:0] BANK_ID_REF [0:15] = '{          // Expected bank-ID bytes
      8'd9,  8'd3,  8'd71, 8'd80, 8'd85, 8'd32,  8'd69,  8'd80,
      8'd52, 8'd67, 8'd69, 8'd54, 8'd0,  8'd255, 8'd255, 8'd255
   };

   logic        GPU_CLK;
   logic        reset;
   z80_bus_t    z80_bus;
   logic [7:0]  gpu_rdata;
   logic        gpu_rd_rdy;
   gpu_req_t    gpu;
   z80_drive_t  z80_drive;
   logic        spkr_en;
   logic        video_en;
   logic [7:0]  kind_q [$];                                  // Transactions from the input file
   logic [21:0] addr_q [$];
   logic [7:0]  data_q [$];
   logic [7:0]  exp_q [$];
   int          n_lines;
   int          errors;
   int          rdy_wait;                                    // RAM model countdown
   logic [31:0] rng;

   z80_gpu_bridge DUT (.GPU_CLK(GPU_CLK), .reset(reset), .z80_bus(z80_bus),
      .gpu_rdata(gpu_rdata), .gpu_rd_rdy(gpu_rd_rdy), .gpu(gpu), .z80_drive(z80_drive),
      .spkr_en(spkr_en), .video_en(video_en));

   always #5 GPU_CLK = !GPU_CLK;                             // 10 ns period

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Byte the RAM model holds at an offset
   function automatic logic [7:0] model_byte(input logic [18:0] a);
      return a[7:0] ^ a[15:8] ^ 8'h3C;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      errors = errors + 1;
      $display("FAIL %0t %s expected %0h got %0h", $time, name, exp, got);
   endtask

   task automatic report_problem(input string msg);
      errors = errors + 1;
      $display("ERROR %0t %s", $time, msg);
   endtask

   task automatic release_strobes();
      z80_bus.mreq_n = 1'b1;
      z80_bus.iorq_n = 1'b1;
      z80_bus.wr_n   = 1'b1;
      z80_bus.rd_n   = 1'b1;
   endtask

   // Level converter controls against the levels of the current class
   task automatic check_controls(input logic ena, input logic dir, input logic oe_n);
      if (z80_drive.rdata_ena !== ena)
         report_mismatch("z80_drive.rdata_ena", 32'(ena), 32'(z80_drive.rdata_ena));
      if (z80_drive.dir_245 !== dir)
         report_mismatch("z80_drive.dir_245", 32'(dir), 32'(z80_drive.dir_245));
      if (z80_drive.oe_245_n !== oe_n)
         report_mismatch("z80_drive.oe_245_n", 32'(oe_n), 32'(z80_drive.oe_245_n));
   endtask

   // **********************************************************************
   // GPU RAM model answering each read request after 2 to 5 cycles
   // **********************************************************************
   always begin
      @(posedge GPU_CLK);
      #1;
      gpu_rd_rdy = 1'b0;
      if (rdy_wait > 0) begin
         rdy_wait = rdy_wait - 1;
         if (rdy_wait == 0) begin
            gpu_rd_rdy = 1'b1;                               // One-cycle answer
            gpu_rdata  = model_byte(gpu.addr);
         end
      end else if (gpu.rd_req) begin
         rng      = xorshift(rng);
         rdy_wait = 2 + int'(rng[1:0]);
      end
   end

   task automatic load_lines();
      int              fd;
      int              code;
      logic [8*128-1:0] skip_buf;
      logic [7:0]      kind;
      logic [21:0]     addr;
      logic [7:0]      data;
      logic [7:0]      exp;
      fd = $fopen("test/bridge_input.txt", "r");
      if (fd == 0) begin
         report_problem("cannot open test/bridge_input.txt");
         return;
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, " %c", kind);
         if (code != 1)
            break;
         if (kind == "#") begin
            code = $fgets(skip_buf, fd);                     // Rest of a comment line
         end else begin
            code = $fscanf(fd, " %h %h %h", addr, data, exp);
            kind_q.push_back(kind);
            addr_q.push_back(addr);
            data_q.push_back(data);
            exp_q.push_back(exp);
            if (kind == "R" && addr[21:4] == BANK_BASE[21:4] && `BRIDGE_BANK_RESPONSE != 0
                && exp != BANK_ID_REF[addr[3:0]])
               report_problem($sformatf("input line for %h disagrees with bank-ID table", addr));
         end
      end
      $fclose(fd);
      n_lines = kind_q.size();
   endtask

   task automatic check_reset_values();
      if (gpu.wr_ena !== 1'b0) report_mismatch("gpu.wr_ena", 0, 32'(gpu.wr_ena));
      if (gpu.rd_req !== 1'b0) report_mismatch("gpu.rd_req", 0, 32'(gpu.rd_req));
      check_controls(1'b0, 1'b0, 1'b1);
      if (spkr_en !== 1'b0) report_mismatch("spkr_en", 0, 32'(spkr_en));
      if (video_en !== 1'b1) report_mismatch("video_en", 1, 32'(video_en));
      if (z80_drive.rdata !== 8'h00) report_mismatch("z80_drive.rdata", 0, 32'(z80_drive.rdata));
   endtask

   // **********************************************************************
   // One host transaction with strobes held 8 cycles then 4 idle cycles
   // **********************************************************************
   task automatic run_line(input int n);
      logic [7:0]  kind;
      logic [21:0] addr;
      logic [7:0]  data;
      logic [7:0]  exp;
      int          wr_seen;
      int          rd_seen;
      int          spkr_seen;
      int          rdy_at;
      kind      = kind_q[n];
      addr      = addr_q[n];
      data      = data_q[n];
      exp       = exp_q[n];
      wr_seen   = 0;
      rd_seen   = 0;
      spkr_seen = 0;
      rdy_at    = -1;
      @(posedge GPU_CLK);
      #1;
      z80_bus.addr   = addr;
      z80_bus.wdata  = data;
      z80_bus.mreq_n = (kind == "I");
      z80_bus.iorq_n = (kind != "I");
      z80_bus.wr_n   = (kind == "R");
      z80_bus.rd_n   = (kind != "R");
      for (int i = 0; i < 12; i++) begin
         @(negedge GPU_CLK);                                 // Outputs settled mid-cycle
         if (gpu.wr_ena || gpu.rd_req) begin
            wr_seen = wr_seen + int'(gpu.wr_ena);
            rd_seen = rd_seen + int'(gpu.rd_req);
            if (i != 2)
               report_problem($sformatf("line %0d GPU pulse in cycle %0d, not 2", n, i));
            if (gpu.addr !== addr[18:0])
               report_mismatch("gpu.addr", 32'(addr[18:0]), 32'(gpu.addr));
            if (gpu.wr_ena && gpu.wdata !== data)
               report_mismatch("gpu.wdata", 32'(data), 32'(gpu.wdata));
         end
         if (spkr_en) begin
            spkr_seen = spkr_seen + 1;
            if (i != 2) report_problem($sformatf("line %0d spkr_en in cycle %0d, not 2", n, i));
         end
         if (rdy_at >= 0 && i == rdy_at + 1 && z80_drive.rdata !== exp)
            report_mismatch("z80_drive.rdata", 32'(exp), 32'(z80_drive.rdata));
         if (gpu_rd_rdy)
            rdy_at = i;                                      // Data due one edge later
         if (i >= 2 && i <= 9) begin
            if (kind == "R")
               check_controls(1'b1, 1'b1, 1'b0);             // Converter drives toward Z80
            else if (kind == "W" && exp != 8'h00)
               check_controls(1'b0, 1'b0, 1'b0);             // In-range write opens it toward FPGA
            else
               check_controls(1'b0, 1'b0, 1'b1);             // No memory class keeps it off
         end
         if (i == 11)
            check_controls(1'b0, 1'b0, 1'b1);                // Idle again after the strobes
         if (i == 7) begin
            @(posedge GPU_CLK);
            #1;
            release_strobes();
         end
      end
      if (kind == "W" && wr_seen != int'(exp))
         report_mismatch("gpu.wr_ena pulses", 32'(exp), wr_seen);
      if (kind != "W" && wr_seen != 0) report_mismatch("gpu.wr_ena pulses", 0, wr_seen);
      if (kind == "R" && rd_seen != 1) report_mismatch("gpu.rd_req pulses", 1, rd_seen);
      if (kind != "R" && rd_seen != 0) report_mismatch("gpu.rd_req pulses", 0, rd_seen);
      if (kind == "R" && rdy_at < 0) report_problem($sformatf("line %0d read got no answer", n));
      if (kind == "I" && addr[7:0] == `BRIDGE_IO_SPKR && spkr_seen != int'(exp))
         report_mismatch("spkr_en pulses", 32'(exp), spkr_seen);
      if (!(kind == "I" && addr[7:0] == `BRIDGE_IO_SPKR) && spkr_seen != 0)
         report_mismatch("spkr_en pulses", 0, spkr_seen);
      if (kind == "I" && addr[7:0] == `BRIDGE_IO_BLNK && video_en !== exp[0])
         report_mismatch("video_en", 32'(exp[0]), 32'(video_en));
   endtask

   initial begin
      GPU_CLK    = 1'b0;
      reset      = 1'b1;
      z80_bus    = '{m1_n: 1'b1, mreq_n: 1'b1, iorq_n: 1'b1, wr_n: 1'b1, rd_n: 1'b1,
                     addr: '0, wdata: '0};
      gpu_rdata  = 8'h00;
      gpu_rd_rdy = 1'b0;
      errors     = 0;
      rdy_wait   = 0;
      rng        = 32'h38e4;
      load_lines();
      repeat (4) @(posedge GPU_CLK);                         // Reset for 4 cycles
      #1;
      reset = 1'b0;
      @(negedge GPU_CLK);
      check_reset_values();
      for (int n = 0; n < n_lines; n++)
         run_line(n);
      $display("Summary: %0d transactions, %0d errors", n_lines, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // Watchdog scaled by the transaction count
   initial begin
      wait (n_lines > 0);
      repeat (n_lines * 20 + 100) @(posedge GPU_CLK);
      $display("ERROR watchdog expired after %0d cycles", n_lines * 20 + 100);
      $display("Regression failed");
      $finish;
   end

endmodule

//--- test/bridge_input.txt
# kind addr data expect, in hex
# W expects the wr_ena pulse count, R the returned byte, I the spkr_en pulse count or video_en
W 100010 A5 1
W 107FFF 3C 1
W 108000 11 0
W 0F0010 22 0
W 17FFF2 33 0
W 104321 5A 1
R 100010 00 2C
R 107FFF 00 BC
R 104321 00 5E
R 100000 00 3C
R 1012AB 00 85
R 17FFF0 00 09
R 17FFF3 00 50
R 17FFF5 00 20
R 17FFFB 00 36
R 17FFFC 00 00
R 17FFFF 00 FF
R 108000 00 FF
R 140000 00 FF
I 0000F2 01 1
I 0000F2 00 0
I 0000F3 00 0
I 0000F3 80 1
I 0000F3 00 0
I 0012F2 7F 1

//--- sources.f
+incdir+src
src/z80_bridge_pkg.sv
src/z80_bus_decode.sv
src/gpu_access_sequencer.sv
src/io_port_control.sv
src/read_data_return.sv
src/z80_gpu_bridge.sv
test/tb_z80_gpu_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_z80_gpu_bridge -f sources.f
./obj_dir/Vtb_z80_gpu_bridge | tee sim.log

if grep -q "Regression failed" sim.log; then
   echo "Simulation reported errors, see sim.log"
   exit 1
fi
echo "Simulation finished without errors"
